/* rtl/perf_pkg.sv */
/*
 * perf_pkg: shared widths, event indices and types of the performance monitor
 */
package perf_pkg;

    // ----------------------------------------------------------------------
    // widths and counts
    // ----------------------------------------------------------------------
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned NR_EVENTS       = 14;

    typedef logic [63:0] counter_t;
    typedef logic [4:0]  csr_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  incr_t;
    typedef incr_t [NR_EVENTS-1:0] event_incr_t;

    // link register used by the calling convention
    localparam reg_idx_t RA_REG = 5'd1;

    // ----------------------------------------------------------------------
    // event indices, also the register address of each counter
    // ----------------------------------------------------------------------
    localparam csr_addr_t EV_ICACHE_MISS = 5'd0;
    localparam csr_addr_t EV_DCACHE_MISS = 5'd1;
    localparam csr_addr_t EV_ITLB_MISS   = 5'd2;
    localparam csr_addr_t EV_DTLB_MISS   = 5'd3;
    localparam csr_addr_t EV_LOAD        = 5'd4;
    localparam csr_addr_t EV_STORE       = 5'd5;
    localparam csr_addr_t EV_CTRL_FLOW   = 5'd6;
    localparam csr_addr_t EV_CALL        = 5'd7;
    localparam csr_addr_t EV_RET         = 5'd8;
    localparam csr_addr_t EV_EXCEPTION   = 5'd9;
    localparam csr_addr_t EV_ERET        = 5'd10;
    localparam csr_addr_t EV_MISPREDICT  = 5'd11;
    localparam csr_addr_t EV_SB_FULL     = 5'd12;
    localparam csr_addr_t EV_IF_EMPTY    = 5'd13;

    // ----------------------------------------------------------------------
    // commit and event types
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        FU_ALU,
        FU_LOAD,
        FU_STORE,
        FU_CTRL_FLOW
    } fu_class_e;

    // jump kinds that tell calls and returns apart
    typedef enum logic [1:0] {
        OP_OTHER,
        OP_JAL,
        OP_JALR
    } op_class_e;

    typedef struct packed {
        logic      valid;
        fu_class_e fu;
        op_class_e op;
        reg_idx_t  rd;
    } commit_instr_t;

    typedef struct packed {
        logic icache_miss;
        logic dcache_miss;
        logic itlb_miss;
        logic dtlb_miss;
        logic exception;
        logic eret;
        logic mispredict;
        logic sb_full;
        logic if_empty;
    } misc_events_t;

endpackage

/* rtl/perf_event_decode.sv */
/*
 * perf_event_decode: classifies commit ports and misc strobes into
 * a registered per-event increment vector
 */
`timescale 1ns/1ps

module perf_event_decode (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  perf_pkg::commit_instr_t [perf_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    input  perf_pkg::misc_events_t                                misc_i,
    output perf_pkg::event_incr_t                                 incr_o
);
    import perf_pkg::*;

    event_incr_t incr_d;
    event_incr_t incr_q;

    // ----------------------------------------------------------------------
    // classification
    // ----------------------------------------------------------------------
    always_comb begin
        incr_d = '0;

        // single strobes count once
        incr_d[EV_ICACHE_MISS] = {1'b0, misc_i.icache_miss};
        incr_d[EV_DCACHE_MISS] = {1'b0, misc_i.dcache_miss};
        incr_d[EV_ITLB_MISS]   = {1'b0, misc_i.itlb_miss};
        incr_d[EV_DTLB_MISS]   = {1'b0, misc_i.dtlb_miss};
        incr_d[EV_EXCEPTION]   = {1'b0, misc_i.exception};
        incr_d[EV_ERET]        = {1'b0, misc_i.eret};
        incr_d[EV_MISPREDICT]  = {1'b0, misc_i.mispredict};
        incr_d[EV_SB_FULL]     = {1'b0, misc_i.sb_full};
        incr_d[EV_IF_EMPTY]    = {1'b0, misc_i.if_empty};

        // both ports add, so an entry may reach two
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].valid) begin
                if (commit_i[p].fu == FU_LOAD) begin
                    incr_d[EV_LOAD] = incr_d[EV_LOAD] + 2'd1;
                end
                if (commit_i[p].fu == FU_STORE) begin
                    incr_d[EV_STORE] = incr_d[EV_STORE] + 2'd1;
                end
                if (commit_i[p].fu == FU_CTRL_FLOW) begin
                    incr_d[EV_CTRL_FLOW] = incr_d[EV_CTRL_FLOW] + 2'd1;
                end
                // call writes the return address to x1
                if (commit_i[p].fu == FU_CTRL_FLOW && commit_i[p].op == OP_JAL &&
                        commit_i[p].rd == RA_REG) begin
                    incr_d[EV_CALL] = incr_d[EV_CALL] + 2'd1;
                end
                if (commit_i[p].op == OP_JALR && commit_i[p].rd == RA_REG) begin
                    incr_d[EV_RET] = incr_d[EV_RET] + 2'd1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // pipeline register, cuts the path from commit
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            incr_q <= '0;
        end else begin
            incr_q <= incr_d;
        end
    end

    assign incr_o = incr_q;

    // misc strobes never add up beyond one
    a_misc_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(incr_o[EV_ICACHE_MISS][1] | incr_o[EV_DCACHE_MISS][1] |
          incr_o[EV_ITLB_MISS][1]   | incr_o[EV_DTLB_MISS][1]   |
          incr_o[EV_EXCEPTION][1]   | incr_o[EV_ERET][1]        |
          incr_o[EV_MISPREDICT][1]  | incr_o[EV_SB_FULL][1]     |
          incr_o[EV_IF_EMPTY][1]));

endmodule

/* rtl/perf_counter_bank.sv */
/*
 * perf_counter_bank: 64-bit event counters, frozen in debug mode,
 * with a write port that overrides the addressed counter
 */
`timescale 1ns/1ps

module perf_counter_bank (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  debug_mode_i,
    input  perf_pkg::event_incr_t incr_i,
    input  logic                  wr_i,
    input  perf_pkg::csr_addr_t   idx_i,
    input  perf_pkg::counter_t    wdata_i,
    output perf_pkg::counter_t    rdata_o
);
    import perf_pkg::*;

    counter_t [NR_EVENTS-1:0] cnt_d;
    counter_t [NR_EVENTS-1:0] cnt_q;

    // ----------------------------------------------------------------------
    // next count
    // ----------------------------------------------------------------------
    always_comb begin
        cnt_d = cnt_q;

        // no counting while the core is halted in debug
        if (!debug_mode_i) begin
            for (int unsigned e = 0; e < NR_EVENTS; e++) begin
                cnt_d[e] = cnt_q[e] + counter_t'(incr_i[e]);
            end
        end

        // write wins over a same-cycle increment
        if (wr_i) begin
            cnt_d[idx_i] = wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // read returns the value before this edge's update
    assign rdata_o = cnt_q[idx_i];

    // range check lives in the register port
    a_wr_mapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_i |-> (idx_i < csr_addr_t'(NR_EVENTS)));

endmodule

/* rtl/perf_csr_port.sv */
/*
 * perf_csr_port: register-port decode, range qualification of writes
 * and registered read data with a one-cycle valid strobe
 */
`timescale 1ns/1ps

module perf_csr_port (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                req_i,
    input  logic                we_i,
    input  perf_pkg::csr_addr_t addr_i,
    input  perf_pkg::counter_t  wdata_i,
    output logic                bank_wr_o,
    output perf_pkg::csr_addr_t bank_idx_o,
    output perf_pkg::counter_t  bank_wdata_o,
    input  perf_pkg::counter_t  bank_rdata_i,
    output logic                rvalid_o,
    output perf_pkg::counter_t  rdata_o
);
    import perf_pkg::*;

    logic     mapped;
    logic     rd_req;
    logic     rvalid_q;
    counter_t rdata_q;

    // ----------------------------------------------------------------------
    // address decode
    // ----------------------------------------------------------------------
    assign mapped = (addr_i < csr_addr_t'(NR_EVENTS));
    assign rd_req = req_i & ~we_i;

    // unmapped writes are dropped here
    assign bank_wr_o    = req_i & we_i & mapped;
    assign bank_idx_o   = addr_i;
    assign bank_wdata_o = wdata_i;

    // ----------------------------------------------------------------------
    // read response
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_req;
        end
    end

    // unmapped reads return zero
    always_ff @(posedge clk_i) begin
        if (rd_req) begin
            rdata_q <= mapped ? bank_rdata_i : '0;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // one response per read, exactly one cycle later
    a_rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_o == $past(req_i && !we_i));

endmodule

/* rtl/perf_monitor_top.sv */
/*
 * perf_monitor_top: event decode, counter bank and register port
 */
`timescale 1ns/1ps

module perf_monitor_top (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic                                                  debug_mode_i,
    input  perf_pkg::commit_instr_t [perf_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    input  perf_pkg::misc_events_t                                misc_i,
    input  logic                                                  req_i,
    input  logic                                                  we_i,
    input  perf_pkg::csr_addr_t                                   addr_i,
    input  perf_pkg::counter_t                                    wdata_i,
    output logic                                                  rvalid_o,
    output perf_pkg::counter_t                                    rdata_o
);
    import perf_pkg::*;

    event_incr_t incr;
    logic        bank_wr;
    csr_addr_t   bank_idx;
    counter_t    bank_wdata;
    counter_t    bank_rdata;

    perf_event_decode u_event_decode (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .commit_i (commit_i),
        .misc_i   (misc_i),
        .incr_o   (incr)
    );

    perf_counter_bank u_counter_bank (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .debug_mode_i (debug_mode_i),
        .incr_i       (incr),
        .wr_i         (bank_wr),
        .idx_i        (bank_idx),
        .wdata_i      (bank_wdata),
        .rdata_o      (bank_rdata)
    );

    perf_csr_port u_csr_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .bank_wr_o    (bank_wr),
        .bank_idx_o   (bank_idx),
        .bank_wdata_o (bank_wdata),
        .bank_rdata_i (bank_rdata),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o)
    );

endmodule

/* testbench/perf_monitor_tb.sv */
/*
 * perf_monitor_tb: random and directed stimulus for the performance monitor,
 * with a cycle-level count model and concurrent checks on every read response
 */
`timescale 1ns/1ps

module perf_monitor_tb;
    import perf_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 200;
    localparam int DEBUG_CYCLES = 40;
    // two random phases, debug phase, reads and writes, then a margin of two
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 2 * RAND_CYCLES + DEBUG_CYCLES + 250);

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    logic                                  debug_mode;
    commit_instr_t [NR_COMMIT_PORTS-1:0]   commit;
    misc_events_t                          misc;
    logic                                  req;
    logic                                  we;
    csr_addr_t                             addr;
    counter_t                              wdata;
    logic                                  rvalid;
    counter_t                              rdata;

    // reference model state
    counter_t    exp_cnt [NR_EVENTS];
    int          pend [NR_EVENTS];
    logic        exp_rvalid;
    counter_t    exp_rdata;
    logic [31:0] r;
    string       test_name;
    int          err_cnt   = 0;
    int          read_cnt  = 0;
    int          cycle_cnt = 0;

    perf_monitor_top u_perf_monitor_top (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .debug_mode_i (debug_mode),
        .commit_i     (commit),
        .misc_i       (misc),
        .req_i        (req),
        .we_i         (we),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .rvalid_o     (rvalid),
        .rdata_o      (rdata)
    );

    always #50 clk = ~clk;

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic is_mapped(csr_addr_t a);
        return a < csr_addr_t'(NR_EVENTS);
    endfunction

    // amount one event gains from this cycle's inputs
    function automatic int event_amount(csr_addr_t ev, commit_instr_t [NR_COMMIT_PORTS-1:0] c,
                                        misc_events_t m);
        int amount;
        amount = 0;
        case (ev)
            EV_ICACHE_MISS: if (m.icache_miss) amount = 1;
            EV_DCACHE_MISS: if (m.dcache_miss) amount = 1;
            EV_ITLB_MISS:   if (m.itlb_miss) amount = 1;
            EV_DTLB_MISS:   if (m.dtlb_miss) amount = 1;
            EV_EXCEPTION:   if (m.exception) amount = 1;
            EV_ERET:        if (m.eret) amount = 1;
            EV_MISPREDICT:  if (m.mispredict) amount = 1;
            EV_SB_FULL:     if (m.sb_full) amount = 1;
            EV_IF_EMPTY:    if (m.if_empty) amount = 1;
            default: begin
                for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                    if (c[p].valid) begin
                        if (ev == EV_LOAD && c[p].fu == FU_LOAD) amount++;
                        if (ev == EV_STORE && c[p].fu == FU_STORE) amount++;
                        if (ev == EV_CTRL_FLOW && c[p].fu == FU_CTRL_FLOW) amount++;
                        if (ev == EV_CALL && c[p].fu == FU_CTRL_FLOW && c[p].op == OP_JAL &&
                                c[p].rd == 5'd1) amount++;
                        if (ev == EV_RET && c[p].op == OP_JALR && c[p].rd == 5'd1) amount++;
                    end
                end
            end
        endcase
        return amount;
    endfunction

    // events wait one edge in pend, then land unless debug is high
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < NR_EVENTS; e++) begin
                exp_cnt[e] <= '0;
                pend[e]    <= 0;
            end
            exp_rvalid <= 1'b0;
            exp_rdata  <= '0;
        end else begin
            exp_rvalid <= req && !we;
            if (req && !we) begin
                exp_rdata <= is_mapped(addr) ? exp_cnt[addr] : '0;
            end
            for (int e = 0; e < NR_EVENTS; e++) begin
                if (!debug_mode) begin
                    exp_cnt[e] <= exp_cnt[e] + counter_t'(pend[e]);
                end
                pend[e] <= event_amount(csr_addr_t'(e), commit, misc);
            end
            if (req && we && is_mapped(addr)) begin
                exp_cnt[addr] <= wdata;
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid == exp_rvalid)
        else begin
            err_cnt = err_cnt + 1;
            $display("mismatch %s rvalid: expected %0b actual %0b", test_name,
                     $sampled(exp_rvalid), $sampled(rvalid));
        end

    a_rdata_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> (rdata == exp_rdata))
        else begin
            err_cnt = err_cnt + 1;
            $display("mismatch %s rdata: expected %h actual %h", test_name,
                     $sampled(exp_rdata), $sampled(rdata));
        end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles in %s", cycle_cnt, test_name);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic clear_events();
        commit = '0;
        misc   = '0;
    endtask

    task automatic read_counter(int a);
        req  = 1'b1;
        we   = 1'b0;
        addr = csr_addr_t'(a);
        read_cnt++;
        step();
        req = 1'b0;
    endtask

    task automatic write_counter(int a, counter_t d);
        req   = 1'b1;
        we    = 1'b1;
        addr  = csr_addr_t'(a);
        wdata = d;
        step();
        req = 1'b0;
        we  = 1'b0;
    endtask

    task automatic read_range(int n);
        for (int a = 0; a < n; a++) begin
            read_counter(a);
        end
    endtask

    function automatic commit_instr_t random_commit();
        commit_instr_t c;
        logic [31:0]   v;
        v       = $urandom;
        c.valid = v[0] | v[11];
        c.fu    = fu_class_e'(v[2:1]);
        c.op    = (v[4:3] == 2'd3) ? OP_OTHER : op_class_e'(v[4:3]);
        // x1 often, so calls and returns show up
        c.rd    = v[5] ? 5'd1 : v[10:6];
        return c;
    endfunction

    function automatic commit_instr_t make_commit(fu_class_e fu, op_class_e op, reg_idx_t rd);
        commit_instr_t c;
        c.valid = 1'b1;
        c.fu    = fu;
        c.op    = op;
        c.rd    = rd;
        return c;
    endfunction

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h4a16));
        rst_n      = 1'b0;
        debug_mode = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        test_name  = "reset";
        clear_events();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;
        step();

        test_name = "reset_reads";
        read_range(32);

        test_name = "misc_random";
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r    = $urandom;
            misc = r[8:0];
            step();
        end
        clear_events();
        repeat (3) step();
        read_range(NR_EVENTS);

        test_name = "commit_random";
        commit[0] = make_commit(FU_LOAD, OP_OTHER, 5'd3);
        commit[1] = make_commit(FU_LOAD, OP_OTHER, 5'd4);
        step();
        commit[0] = make_commit(FU_CTRL_FLOW, OP_JAL, 5'd1);
        commit[1] = make_commit(FU_CTRL_FLOW, OP_JAL, 5'd1);
        step();
        commit[0] = make_commit(FU_CTRL_FLOW, OP_JALR, 5'd1);
        commit[1] = make_commit(FU_CTRL_FLOW, OP_JALR, 5'd1);
        step();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            commit[0] = random_commit();
            commit[1] = random_commit();
            step();
        end
        clear_events();
        repeat (3) step();
        read_range(NR_EVENTS);

        test_name  = "debug_freeze";
        debug_mode = 1'b1;
        step();
        for (int i = 0; i < DEBUG_CYCLES; i++) begin
            r         = $urandom;
            misc      = r[8:0];
            commit[0] = random_commit();
            commit[1] = random_commit();
            step();
        end
        clear_events();
        repeat (3) step();
        debug_mode = 1'b0;
        step();
        read_range(NR_EVENTS);

        test_name = "write_readback";
        write_counter(EV_LOAD, 64'hdead_beef_0123_4567);
        read_counter(EV_LOAD);
        // increment lands in the same cycle as the write
        commit[0] = make_commit(FU_LOAD, OP_OTHER, 5'd2);
        commit[1] = make_commit(FU_LOAD, OP_OTHER, 5'd5);
        step();
        clear_events();
        write_counter(EV_LOAD, 64'h0000_0000_0000_0abc);
        repeat (2) step();
        read_counter(EV_LOAD);
        for (int a = 0; a < NR_EVENTS; a++) begin
            write_counter(a, {$urandom, $urandom});
        end
        read_range(NR_EVENTS);

        test_name = "unmapped";
        for (int a = NR_EVENTS; a < 32; a++) begin
            write_counter(a, {$urandom, $urandom});
        end
        read_range(32);

        repeat (3) step();
        $display("reads issued %0d, errors %0d", read_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/perf_pkg.sv
rtl/perf_event_decode.sv
rtl/perf_counter_bank.sv
rtl/perf_csr_port.sv
rtl/perf_monitor_top.sv
testbench/perf_monitor_tb.sv

/* Makefile */
TOP := perf_monitor_tb
SRCS := $(wildcard rtl/*.sv testbench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

# pass only when the pass message appears in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
